// File: ctrl_pkg.sv
package ctrl_pkg;

  //////////////////////////////////////////////////////////////////////
  // widths
  //////////////////////////////////////////////////////////////////////

  localparam int instr_w   = 16;
  localparam int reg_cnt   = 8;
  localparam int reg_idx_w = 3;
  // whatever is left below the register field
  localparam int low_w     = instr_w - 4 - 2 - 3 - reg_idx_w;

  //////////////////////////////////////////////////////////////////////
  // instruction
  //////////////////////////////////////////////////////////////////////

  typedef struct packed {
    logic [3:0]           opcode;
    logic [1:0]           sub;
    logic [2:0]           middle;
    logic [reg_idx_w-1:0] reg_field;
    logic [low_w-1:0]     low;
  } instr_t;

  typedef enum logic [3:0] {
    br_uc    = 4'b0000,
    br_c     = 4'b0001,
    br_nc    = 4'b0010,
    br_z     = 4'b0011,
    br_nz    = 4'b0100,
    br_v     = 4'b0101,
    br_nv    = 4'b0110,
    br_s     = 4'b0111,
    br_ns    = 4'b1000,
    op_call  = 4'b1001,
    op_stack = 4'b1111
  } opcode_e;

  typedef enum logic [1:0] {cls_branch, cls_call, cls_push, cls_pop} instr_class_e;

  typedef struct packed {
    logic c;
    logic z;
    logic v;
    logic s;
  } flags_t;

  //////////////////////////////////////////////////////////////////////
  // control word
  //////////////////////////////////////////////////////////////////////

  // encoding follows the datapath ALU select
  typedef enum logic [2:0] {
    fn_trans = 3'b000,
    fn_inc   = 3'b001,
    fn_dec   = 3'b010,
    fn_add   = 3'b011,
    fn_neg   = 3'b100,
    fn_or    = 3'b101,
    fn_not   = 3'b110
  } alu_fn_e;

  typedef struct packed {
    logic t_pc;
    logic l_pc;
    logic t_mar;
    logic l_mar;
    logic t_mdr;
    logic l_mdr;
    logic l_ir;
    logic t_ir;
    logic t_sp;
    logic l_sp;
    logic l_reg_en;
  } bus_ctrl_t;

  // one-hot per general register
  typedef struct packed {
    logic [reg_cnt-1:0] t_reg;
    logic [reg_cnt-1:0] l_reg;
  } reg_en_t;

  typedef enum logic [4:0] {
    fetch_addr, fetch_mem, fetch_ir, fetch_inc, decode,
    br_test, jump,
    call_save, push_src, sp_dec, sp_addr, push_mem,
    pop_addr, pop_mem, pop_load, sp_inc
  } ctrl_state_e;

endpackage

// File: instr_decoder.sv
module instr_decoder (
  input  ctrl_pkg::instr_t       ir,
  input  ctrl_pkg::flags_t       flags,
  output ctrl_pkg::instr_class_e instr_class,
  output logic                   cond_taken
);

  //////////////////////////////////////////////////////////////////////
  // instruction class
  //////////////////////////////////////////////////////////////////////

  always_comb
  begin
    case (ir.opcode)
      ctrl_pkg::op_call:
        instr_class = ctrl_pkg::cls_call;
      ctrl_pkg::op_stack:
      begin
        // sub 00 pushes, anything else pops
        if (ir.sub == 2'b00)
          instr_class = ctrl_pkg::cls_push;
        else
          instr_class = ctrl_pkg::cls_pop;
      end
      default:
        instr_class = ctrl_pkg::cls_branch;
    endcase
  end

  //////////////////////////////////////////////////////////////////////
  // branch condition
  //////////////////////////////////////////////////////////////////////

  always_comb
  begin
    case (ir.opcode)
      ctrl_pkg::br_uc: cond_taken = 1'b1;
      ctrl_pkg::br_c:  cond_taken = flags.c;
      ctrl_pkg::br_nc: cond_taken = !flags.c;
      ctrl_pkg::br_z:  cond_taken = flags.z;
      ctrl_pkg::br_nz: cond_taken = !flags.z;
      ctrl_pkg::br_v:  cond_taken = flags.v;
      ctrl_pkg::br_nv: cond_taken = !flags.v;
      ctrl_pkg::br_s:  cond_taken = flags.s;
      ctrl_pkg::br_ns: cond_taken = !flags.s;
      // call, stack and unused opcodes never branch here
      default:         cond_taken = 1'b0;
    endcase
  end

endmodule

// File: mem_handshake.sv
module mem_handshake (
  input  logic clk,
  input  logic arst_n,
  input  logic mem_start,
  input  logic mem_write,
  input  logic mem_ack,
  output logic mem_req,
  output logic mem_we,
  output logic mem_done
);

  typedef enum logic [1:0] {idle, wait_ack_high, wait_ack_low} hs_state_e;

  hs_state_e hs_state;

  // four-phase master with registered req and we
  always_ff @(posedge clk or negedge arst_n)
  begin
    if (!arst_n)
    begin
      hs_state <= idle;
      mem_req  <= 1'b0;
      mem_we   <= 1'b0;
      mem_done <= 1'b0;
    end
    else
    begin
      mem_done <= 1'b0;
      case (hs_state)
        idle:
        begin
          // ack is back low here since the last done
          if (mem_start)
          begin
            mem_req  <= 1'b1;
            mem_we   <= mem_write;
            hs_state <= wait_ack_high;
          end
        end
        wait_ack_high:
        begin
          if (mem_ack)
          begin
            mem_req  <= 1'b0;
            hs_state <= wait_ack_low;
          end
        end
        wait_ack_low:
        begin
          if (!mem_ack)
          begin
            mem_done <= 1'b1;
            hs_state <= idle;
          end
        end
        default:
          hs_state <= idle;
      endcase
    end
  end

endmodule

// File: ctrl_fsm.sv
module ctrl_fsm (
  input  logic                   clk,
  input  logic                   arst_n,
  input  ctrl_pkg::instr_class_e instr_class,
  input  logic                   cond_taken,
  input  logic                   mem_done,
  output ctrl_pkg::ctrl_state_e  state,
  output logic                   mem_start,
  output logic                   mem_write
);

  ctrl_pkg::ctrl_state_e state_d;
  logic                  mem_now;
  logic                  mem_next;

  always_ff @(posedge clk or negedge arst_n)
  begin
    if (!arst_n)
      state <= ctrl_pkg::fetch_addr;
    else
      state <= state_d;
  end

  //////////////////////////////////////////////////////////////////////
  // next state
  //////////////////////////////////////////////////////////////////////

  always_comb
  begin
    state_d = state;
    case (state)
      ctrl_pkg::fetch_addr: state_d = ctrl_pkg::fetch_mem;
      ctrl_pkg::fetch_mem:
      begin
        if (mem_done)
          state_d = ctrl_pkg::fetch_ir;
      end
      ctrl_pkg::fetch_ir:   state_d = ctrl_pkg::fetch_inc;
      ctrl_pkg::fetch_inc:  state_d = ctrl_pkg::decode;
      ctrl_pkg::decode:
      begin
        case (instr_class)
          ctrl_pkg::cls_call: state_d = ctrl_pkg::call_save;
          ctrl_pkg::cls_push: state_d = ctrl_pkg::push_src;
          ctrl_pkg::cls_pop:  state_d = ctrl_pkg::pop_addr;
          default:            state_d = ctrl_pkg::br_test;
        endcase
      end
      ctrl_pkg::br_test:
      begin
        if (cond_taken)
          state_d = ctrl_pkg::jump;
        else
          state_d = ctrl_pkg::fetch_addr;
      end
      ctrl_pkg::jump:       state_d = ctrl_pkg::fetch_addr;
      // call and push share the stack write
      ctrl_pkg::call_save:  state_d = ctrl_pkg::sp_dec;
      ctrl_pkg::push_src:   state_d = ctrl_pkg::sp_dec;
      ctrl_pkg::sp_dec:     state_d = ctrl_pkg::sp_addr;
      ctrl_pkg::sp_addr:    state_d = ctrl_pkg::push_mem;
      ctrl_pkg::push_mem:
      begin
        if (mem_done)
        begin
          if (instr_class == ctrl_pkg::cls_call)
            state_d = ctrl_pkg::jump;
          else
            state_d = ctrl_pkg::fetch_addr;
        end
      end
      ctrl_pkg::pop_addr:   state_d = ctrl_pkg::pop_mem;
      ctrl_pkg::pop_mem:
      begin
        if (mem_done)
          state_d = ctrl_pkg::pop_load;
      end
      ctrl_pkg::pop_load:   state_d = ctrl_pkg::sp_inc;
      ctrl_pkg::sp_inc:     state_d = ctrl_pkg::fetch_addr;
      default:              state_d = ctrl_pkg::fetch_addr;
    endcase
  end

  //////////////////////////////////////////////////////////////////////
  // handshake start
  //////////////////////////////////////////////////////////////////////

  assign mem_now  = (state == ctrl_pkg::fetch_mem) || (state == ctrl_pkg::push_mem) ||
                    (state == ctrl_pkg::pop_mem);
  assign mem_next = (state_d == ctrl_pkg::fetch_mem) || (state_d == ctrl_pkg::push_mem) ||
                    (state_d == ctrl_pkg::pop_mem);

  // high for one cycle on the edge that enters a memory state
  assign mem_start = mem_next && !mem_now;
  assign mem_write = (state_d == ctrl_pkg::push_mem);

endmodule

// File: ctrl_word_gen.sv
module ctrl_word_gen (
  input  ctrl_pkg::ctrl_state_e        state,
  input  logic [ctrl_pkg::reg_idx_w-1:0] reg_field,
  output ctrl_pkg::bus_ctrl_t          bus,
  output ctrl_pkg::reg_en_t            regs,
  output ctrl_pkg::alu_fn_e            alu_fn
);

  // memory states and decode leave everything low
  always_comb
  begin
    bus    = '0;
    regs   = '0;
    alu_fn = ctrl_pkg::fn_trans;
    case (state)
      ctrl_pkg::fetch_addr:
      begin
        bus.t_pc  = 1'b1;
        bus.l_mar = 1'b1;
      end
      ctrl_pkg::fetch_ir:
      begin
        bus.t_mdr = 1'b1;
        bus.l_ir  = 1'b1;
      end
      ctrl_pkg::fetch_inc:
      begin
        bus.t_pc  = 1'b1;
        bus.l_pc  = 1'b1;
        alu_fn    = ctrl_pkg::fn_inc;
      end
      // pc plus the offset from ir
      ctrl_pkg::jump:
      begin
        bus.t_ir  = 1'b1;
        bus.t_pc  = 1'b1;
        bus.l_pc  = 1'b1;
        alu_fn    = ctrl_pkg::fn_add;
      end
      ctrl_pkg::call_save:
      begin
        bus.t_pc  = 1'b1;
        bus.l_mdr = 1'b1;
      end
      ctrl_pkg::push_src:
      begin
        regs.t_reg[reg_field] = 1'b1;
        bus.l_mdr             = 1'b1;
      end
      ctrl_pkg::sp_dec:
      begin
        bus.t_sp  = 1'b1;
        bus.l_sp  = 1'b1;
        alu_fn    = ctrl_pkg::fn_dec;
      end
      ctrl_pkg::sp_addr, ctrl_pkg::pop_addr:
      begin
        bus.t_sp  = 1'b1;
        bus.l_mar = 1'b1;
      end
      ctrl_pkg::pop_load:
      begin
        bus.t_mdr             = 1'b1;
        regs.l_reg[reg_field] = 1'b1;
        bus.l_reg_en          = 1'b1;
      end
      ctrl_pkg::sp_inc:
      begin
        bus.t_sp  = 1'b1;
        bus.l_sp  = 1'b1;
        alu_fn    = ctrl_pkg::fn_inc;
      end
      default:
      begin
        bus    = '0;
        regs   = '0;
        alu_fn = ctrl_pkg::fn_trans;
      end
    endcase
  end

endmodule

// File: cpu_ctrl.sv
module cpu_ctrl (
  input  logic                clk,
  input  logic                arst_n,
  input  ctrl_pkg::instr_t    ir,
  input  ctrl_pkg::flags_t    flags,
  input  logic                mem_ack,
  output ctrl_pkg::bus_ctrl_t bus,
  output ctrl_pkg::reg_en_t   regs,
  output ctrl_pkg::alu_fn_e   alu_fn,
  output logic                mem_req,
  output logic                mem_we
);

  ctrl_pkg::instr_class_e instr_class;
  ctrl_pkg::ctrl_state_e  state;
  logic                   cond_taken;
  logic                   mem_start;
  logic                   mem_write;
  logic                   mem_done;

  instr_decoder u_decoder (
    .ir          (ir),
    .flags       (flags),
    .instr_class (instr_class),
    .cond_taken  (cond_taken)
  );

  ctrl_fsm u_fsm (
    .clk         (clk),
    .arst_n      (arst_n),
    .instr_class (instr_class),
    .cond_taken  (cond_taken),
    .mem_done    (mem_done),
    .state       (state),
    .mem_start   (mem_start),
    .mem_write   (mem_write)
  );

  mem_handshake u_mem (
    .clk       (clk),
    .arst_n    (arst_n),
    .mem_start (mem_start),
    .mem_write (mem_write),
    .mem_ack   (mem_ack),
    .mem_req   (mem_req),
    .mem_we    (mem_we),
    .mem_done  (mem_done)
  );

  ctrl_word_gen u_word (
    .state     (state),
    .reg_field (ir.reg_field),
    .bus       (bus),
    .regs      (regs),
    .alu_fn    (alu_fn)
  );

endmodule

// File: tb_cpu_ctrl.sv
module tb_cpu_ctrl;

  logic                clk;
  logic                arst_n;
  ctrl_pkg::instr_t    ir;
  ctrl_pkg::flags_t    flags;
  logic                mem_ack;
  ctrl_pkg::bus_ctrl_t bus;
  ctrl_pkg::reg_en_t   regs;
  ctrl_pkg::alu_fn_e   alu_fn;
  logic                mem_req;
  logic                mem_we;
  logic [29:0]         word;
  logic [29:0]         fetch_word;

  // expected and observed streams
  logic [29:0] exp_words[$];
  logic        exp_we[$];
  logic        seen_we[$];

  cpu_ctrl dut (
    .clk     (clk),
    .arst_n  (arst_n),
    .ir      (ir),
    .flags   (flags),
    .mem_ack (mem_ack),
    .bus     (bus),
    .regs    (regs),
    .alu_fn  (alu_fn),
    .mem_req (mem_req),
    .mem_we  (mem_we)
  );

  assign word = {bus, regs, alu_fn};

  initial
  begin
    clk = 1'b0;
    forever #2 clk = ~clk;
  end

  function automatic logic [31:0] xorshift32(input logic [31:0] x);
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    return x;
  endfunction

  // bus bits from msb are t_pc l_pc t_mar l_mar t_mdr l_mdr l_ir t_ir t_sp l_sp l_reg_en
  function automatic logic [29:0] pack_word(input logic [10:0] b, input logic [7:0] tr,
                                            input logic [7:0] lr, input ctrl_pkg::alu_fn_e f);
    return {b, tr, lr, f};
  endfunction

  task automatic halt_run(input string why);
    $display("%s", why);
    $display("FAIL: see errors above");
    $fatal(1);
  endtask

  task automatic check_value(input string name, input logic [31:0] got, input logic [31:0] exp);
    if (got !== exp)
      halt_run($sformatf("MISMATCH %s: got %h, expected %h", name, got, exp));
  endtask

  //////////////////////////////////////////////////////////////////////
  // reference model
  //////////////////////////////////////////////////////////////////////

  function automatic void predict_instr(input ctrl_pkg::instr_t ins, input ctrl_pkg::flags_t fl);
    logic [7:0] oh;
    logic [3:0] fv;
    logic       taken;
    int         sel;
    oh = 8'b1 << ins.reg_field;
    fv = fl;
    exp_words.push_back(pack_word(11'b1001_0000_000, 8'h0, 8'h0, ctrl_pkg::fn_trans));
    exp_we.push_back(1'b0);
    exp_words.push_back(pack_word(11'b0000_1010_000, 8'h0, 8'h0, ctrl_pkg::fn_trans));
    exp_words.push_back(pack_word(11'b1100_0000_000, 8'h0, 8'h0, ctrl_pkg::fn_inc));
    if (ins.opcode == 4'd9 || (ins.opcode == 4'd15 && ins.sub == 2'b00))
    begin
      // call saves pc and push saves the register before the write below sp
      if (ins.opcode == 4'd9)
        exp_words.push_back(pack_word(11'b1000_0100_000, 8'h0, 8'h0, ctrl_pkg::fn_trans));
      else
        exp_words.push_back(pack_word(11'b0000_0100_000, oh, 8'h0, ctrl_pkg::fn_trans));
      exp_words.push_back(pack_word(11'b0000_0000_110, 8'h0, 8'h0, ctrl_pkg::fn_dec));
      exp_words.push_back(pack_word(11'b0001_0000_100, 8'h0, 8'h0, ctrl_pkg::fn_trans));
      exp_we.push_back(1'b1);
      taken = (ins.opcode == 4'd9);
    end
    else if (ins.opcode == 4'd15)
    begin
      exp_words.push_back(pack_word(11'b0001_0000_100, 8'h0, 8'h0, ctrl_pkg::fn_trans));
      exp_we.push_back(1'b0);
      exp_words.push_back(pack_word(11'b0000_1000_001, 8'h0, oh, ctrl_pkg::fn_trans));
      exp_words.push_back(pack_word(11'b0000_0000_110, 8'h0, 8'h0, ctrl_pkg::fn_inc));
      taken = 1'b0;
    end
    else if (ins.opcode == 4'd0)
      taken = 1'b1;
    else if (ins.opcode <= 4'd8)
    begin
      // odd opcodes need the flag set and even ones need it clear
      // flag order from msb is c z v s
      sel = (int'(ins.opcode) - 1) / 2;
      taken = fv[3 - sel] ^ !ins.opcode[0];
    end
    else
      taken = 1'b0;
    if (taken)
      exp_words.push_back(pack_word(11'b1100_0001_000, 8'h0, 8'h0, ctrl_pkg::fn_add));
  endfunction

  //////////////////////////////////////////////////////////////////////
  // compare and memory responder
  //////////////////////////////////////////////////////////////////////

  always @(posedge clk)
  begin
    if (arst_n)
    begin
      if (word != '0)
      begin
        if (exp_words.size() == 0)
          halt_run("a control word appeared when none was expected");
        else
          check_value("control word", word, exp_words.pop_front());
      end
      if (seen_we.size() != 0)
      begin
        if (exp_we.size() == 0)
          halt_run("a memory access started when none was expected");
        else
          check_value("mem_we", seen_we.pop_front(), exp_we.pop_front());
      end
    end
  end

  initial
  begin
    int          delay;
    int          hold;
    logic        req_q;
    logic [31:0] ack_rng;
    mem_ack = 1'b0;
    req_q   = 1'b0;
    delay   = 0;
    hold    = 0;
    ack_rng = 32'h0f80_1b7e;
    forever
    begin
      @(negedge clk);
      if (mem_req && !req_q)
      begin
        if (mem_ack)
          halt_run("mem_req rose while mem_ack was still high");
        seen_we.push_back(mem_we);
        // random rise delay and hold time of ack
        ack_rng = xorshift32(ack_rng);
        delay   = ack_rng % 4;
        hold    = ack_rng[10:8];
      end
      if (mem_ack && !mem_req)
      begin
        if (hold == 0)
          mem_ack = 1'b0;
        else
          hold--;
      end
      else if (mem_req && !mem_ack)
      begin
        if (delay == 0)
          mem_ack = 1'b1;
        else
          delay--;
      end
      req_q = mem_req;
    end
  end

  // starts in fetch_addr and returns at the next fetch_addr
  task automatic run_instr(input ctrl_pkg::instr_t ins, input ctrl_pkg::flags_t fl);
    int cycles;
    ir     = ins;
    flags  = fl;
    cycles = 0;
    predict_instr(ins, fl);
    @(negedge clk);
    while (word !== fetch_word)
    begin
      if (cycles == 60)
        halt_run($sformatf("timeout: instruction %h did not return to fetch in 60 cycles", ins));
      cycles++;
      @(negedge clk);
    end
    check_value("pending control words", exp_words.size(), 0);
    check_value("pending memory accesses", exp_we.size(), 0);
  endtask

  initial
  begin
    int               k;
    logic [31:0]      rng;
    ctrl_pkg::instr_t ins;
    arst_n     = 1'b0;
    ir         = '0;
    flags      = '0;
    rng        = 32'h0f80_1b7e;
    fetch_word = pack_word(11'b1001_0000_000, 8'h0, 8'h0, ctrl_pkg::fn_trans);
    repeat (2) @(negedge clk);
    arst_n = 1'b1;
    check_value("mem_req", mem_req, 0);
    check_value("control word", word, fetch_word);
    // each condition with a flag set and its complement
    for (k = 0; k <= 8; k++)
    begin
      rng = xorshift32(rng);
      ins = rng[15:0];
      ins.opcode = k[3:0];
      run_instr(ins, rng[19:16]);
      run_instr(ins, ~rng[19:16]);
    end
    // push, pop and call
    for (k = 0; k < 8; k++)
    begin
      rng = xorshift32(rng);
      ins = rng[15:0];
      ins.opcode = 4'hf;
      ins.sub = 2'b00;
      run_instr(ins, rng[19:16]);
      ins.sub = (rng[21:20] == 2'b00) ? 2'b10 : rng[21:20];
      run_instr(ins, rng[23:20]);
      ins.opcode = 4'h9;
      run_instr(ins, rng[27:24]);
    end
    $display("PASS: all tests");
    $finish;
  end

endmodule

// File: cpu_ctrl.f
ctrl_pkg.sv
instr_decoder.sv
mem_handshake.sv
ctrl_fsm.sv
ctrl_word_gen.sv
cpu_ctrl.sv
tb_cpu_ctrl.sv

// File: Bender.yml
package:
  name: cpu_ctrl

sources:
  - ctrl_pkg.sv
  - instr_decoder.sv
  - mem_handshake.sv
  - ctrl_fsm.sv
  - ctrl_word_gen.sv
  - cpu_ctrl.sv
  - target: test
    files:
      - tb_cpu_ctrl.sv
